//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_knight
FILELIST  = knight_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- knight_pkg.sv
// Heading codes, opcodes, response bytes, widths and the command word union.
`default_nettype none

package knight_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths.
  //////////////////////////////////////////////////////////////////////
  localparam int MV_INDX_W = 5;  // Move index into the tour store.
  localparam int COORD_W   = 3;  // One board coordinate, wraps modulo 8.
  localparam int MOVE_W    = 8;  // One-hot move.
  localparam int CMD_W     = 16; // Command word.

  // Headings as the executor understands them.
  typedef enum logic [7:0] {
    NORTH = 8'h00,
    WEST  = 8'h3F,
    SOUTH = 8'h7F,
    EAST  = 8'hBF
  } heading_t;

  localparam logic [3:0] OP_MOVE         = 4'h4; // Plain move.
  localparam logic [3:0] OP_MOVE_FANFARE = 4'h5; // Move that closes an L.
  localparam logic [3:0] OP_PLACE        = 4'h6; // Jump straight to x,y.

  localparam logic [7:0] RESP_DONE = 8'hA5; // Last leg, or a host command.
  localparam logic [7:0] RESP_BUSY = 8'h5A; // Tour still running.

  //////////////////////////////////////////////////////////////////////
  // Command word, seen as a move or as a place.
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [3:0] opcode;
    heading_t   heading;
    logic [3:0] squares;  // Squares to step along the heading.
  } move_view_t;

  typedef struct packed {
    logic [3:0]         opcode;
    logic [5:0]         unused;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } place_view_t;

  typedef union packed {
    move_view_t  mv;
    place_view_t pl;
  } cmd_word_u;

endpackage

`default_nettype wire

//--- knight_top.f
knight_pkg.sv
move_store.sv
tour_cmd.sv
move_exec.sv
knight_top.sv
tb_knight.sv

//--- knight_top.sv
// Top level joining the move store, tour sequencer and motion executor.
`timescale 1ns/1ps
`default_nettype none

module knight_top #(
  parameter int NUM_MOVES     = 24,
  parameter int SQUARE_CYCLES = 4
) (
  input  wire  logic                          clk,
  input  wire  logic                          rst_n,
  input  wire  logic [knight_pkg::MOVE_W-1:0] load_move,
  input  wire  logic                          load_valid,
  input  wire  logic                          start_tour,
  input  wire  logic [knight_pkg::CMD_W-1:0]  host_cmd,
  input  wire  logic                          host_cmd_valid,
  output logic                                load_ready,
  output logic                                host_cmd_ready,
  output logic [7:0]                          resp,
  output logic                                resp_valid,
  output logic                                fanfare,
  output logic [knight_pkg::COORD_W-1:0]      pos_x,
  output logic [knight_pkg::COORD_W-1:0]      pos_y,
  output logic                                tour_busy
);

  ////////////////////////////////////////////////////////////////////////
  // Internal links.
  ////////////////////////////////////////////////////////////////////////
  logic [knight_pkg::MOVE_W-1:0]    move;       // Move at the current index.
  logic [knight_pkg::MV_INDX_W-1:0] mv_indx;
  knight_pkg::cmd_word_u            cmd;        // Muxed command to the executor.
  logic                             cmd_rdy;
  logic                             clr_cmd_rdy;
  logic                             send_resp;
  logic [7:0]                       tour_resp;  // Response byte chosen by the sequencer.

  move_store #(.NUM_MOVES(NUM_MOVES)) u_store (
    .clk, .rst_n, .load_move, .load_valid, .start_tour, .tour_busy, .mv_indx,
    .load_ready, .move
  );

  tour_cmd #(.NUM_MOVES(NUM_MOVES)) u_tour (
    .clk, .rst_n, .start_tour, .move, .host_cmd, .host_cmd_valid, .clr_cmd_rdy,
    .send_resp, .mv_indx, .host_cmd_ready, .cmd, .cmd_rdy, .resp(tour_resp), .tour_busy
  );

  move_exec #(.SQUARE_CYCLES(SQUARE_CYCLES)) u_exec (
    .clk, .rst_n, .cmd, .cmd_rdy, .resp(tour_resp), .clr_cmd_rdy, .send_resp,
    .resp_out(resp), .resp_valid, .fanfare, .pos_x, .pos_y
  );

endmodule

`default_nettype wire

//--- move_exec.sv
// Motion executor that steps the knight square by square and pulses the response.
`timescale 1ns/1ps
`default_nettype none

module move_exec #(
  parameter int SQUARE_CYCLES = 4
) (
  input  wire  logic                           clk,
  input  wire  logic                           rst_n,
  input  wire  knight_pkg::cmd_word_u          cmd,
  input  wire  logic                           cmd_rdy,
  input  wire  logic [7:0]                     resp,
  output logic                                 clr_cmd_rdy,
  output logic                                 send_resp,
  output logic [7:0]                           resp_out,
  output logic                                 resp_valid,
  output logic                                 fanfare,
  output logic [knight_pkg::COORD_W-1:0]       pos_x,
  output logic [knight_pkg::COORD_W-1:0]       pos_y
);

  localparam int TMR_W = (SQUARE_CYCLES > 1) ? $clog2(SQUARE_CYCLES) : 1;
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(SQUARE_CYCLES - 1);

  logic                 moving;      // A move is being stepped out.
  logic [3:0]           sq_left;     // Squares still to go.
  logic [TMR_W-1:0]     tmr;         // Cycles spent on this square.
  logic                 step;
  logic                 is_move;
  logic                 is_fan;
  knight_pkg::heading_t head;        // Heading of the move in flight.
  logic                 fan_mv;      // Move in flight closes an L.

  assign is_fan      = (cmd.mv.opcode == knight_pkg::OP_MOVE_FANFARE);
  assign is_move     = (cmd.mv.opcode == knight_pkg::OP_MOVE) || is_fan;
  assign clr_cmd_rdy = !moving && cmd_rdy;   // Take a command only when idle.
  assign step        = moving && (tmr == TMR_LAST);

  assign resp_out   = resp;          // Byte comes from the sequencer.
  assign resp_valid = send_resp;

  // Move payload, held for the length of the move.
  always_ff @(posedge clk) begin
    if (clr_cmd_rdy) begin
      head   <= cmd.mv.heading;
      fan_mv <= is_fan;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command execution and position.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      moving    <= 1'b0;
      sq_left   <= '0;
      tmr       <= '0;
      send_resp <= 1'b0;
      fanfare   <= 1'b0;
      pos_x     <= '0;
      pos_y     <= '0;
    end else begin
      send_resp <= 1'b0;             // Pulses by default.
      fanfare   <= 1'b0;
      if (clr_cmd_rdy) begin
        if (is_move && cmd.mv.squares != 4'd0) begin
          moving  <= 1'b1;
          sq_left <= cmd.mv.squares;
          tmr     <= '0;
        end else begin
          send_resp <= 1'b1;         // Place, zero squares, or unknown opcode.
          fanfare   <= is_fan;
          if (cmd.pl.opcode == knight_pkg::OP_PLACE) begin
            pos_x <= cmd.pl.x;
            pos_y <= cmd.pl.y;
          end
        end
      end else if (moving) begin
        tmr <= step ? '0 : tmr + 1'b1;
        if (step) begin
          case (head)
            knight_pkg::NORTH: pos_y <= pos_y + 1'b1;   // North is +y.
            knight_pkg::SOUTH: pos_y <= pos_y - 1'b1;
            knight_pkg::EAST:  pos_x <= pos_x + 1'b1;   // East is +x.
            knight_pkg::WEST:  pos_x <= pos_x - 1'b1;
            default: ;
          endcase
          sq_left <= sq_left - 1'b1;
          if (sq_left == 4'd1) begin
            moving    <= 1'b0;       // Idle again in the response cycle.
            send_resp <= 1'b1;
            fanfare   <= fan_mv;
          end
        end
      end
    end
  end

  // An offered command stays up and unchanged until it is taken.
  a_offer_held : assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy && !clr_cmd_rdy |=> cmd_rdy && $stable(cmd));

endmodule

`default_nettype wire

//--- move_store.sv
// Tour move memory with a valid/ready load port and an indexed read port.
`timescale 1ns/1ps
`default_nettype none

module move_store #(
  parameter int NUM_MOVES = 24
) (
  input  wire  logic                             clk,
  input  wire  logic                             rst_n,
  input  wire  logic [knight_pkg::MOVE_W-1:0]    load_move,
  input  wire  logic                             load_valid,
  input  wire  logic                             start_tour,
  input  wire  logic                             tour_busy,
  input  wire  logic [knight_pkg::MV_INDX_W-1:0] mv_indx,
  output logic                                   load_ready,
  output logic [knight_pkg::MOVE_W-1:0]          move
);

  localparam int IW = knight_pkg::MV_INDX_W;
  localparam logic [IW-1:0] DEPTH = IW'(NUM_MOVES);

  logic [knight_pkg::MOVE_W-1:0] mem [NUM_MOVES]; // One-hot moves.
  logic [IW-1:0]                 wr_ptr;          // Next free slot.
  logic                          wr_en;

  // Closed during a replay, while full, and in the start cycle.
  assign load_ready = !tour_busy && !start_tour && (wr_ptr != DEPTH);
  assign wr_en      = load_valid && load_ready;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      wr_ptr <= '0;
    else if (start_tour)
      wr_ptr <= '0;                 // Next load starts a fresh tour.
    else if (wr_en)
      wr_ptr <= wr_ptr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= load_move;
  end

  assign move = mem[mv_indx];      // Read is combinational.

  // A replay leaves the stored tour and its fill level alone.
  a_no_load_in_tour : assert property (@(posedge clk) disable iff (!rst_n)
    tour_busy |=> $stable(wr_ptr));

endmodule

`default_nettype wire

//--- tb_knight.sv
// Testbench with clock, reset, random host and tour stimulus, board model, checks and watchdog.
`timescale 1ns/1ps
`default_nettype none

module tb_knight;

  localparam int NUM_MOVES     = 24;
  localparam int SQUARE_CYCLES = 4;
  localparam int PERIOD        = 100;
  localparam int N_HOST        = 20;            // Random host commands in test 2.
  localparam int N_LEGS        = 2 * NUM_MOVES;
  localparam int TOUR_LIMIT    = N_LEGS * (1 + 2 * SQUARE_CYCLES + 4);
  localparam int HOST_LIMIT    = (N_HOST + 2) * (3 + 15 * SQUARE_CYCLES);
  localparam int WATCHDOG_CYCLES = 3 * (TOUR_LIMIT + 2 * NUM_MOVES) + HOST_LIMIT + 100;

  logic        clk;
  logic        rst_n;
  logic [7:0]  load_move;
  logic        load_valid;
  logic        start_tour;
  logic [15:0] host_cmd;
  logic        host_cmd_valid;
  logic        load_ready;
  logic        host_cmd_ready;
  logic [7:0]  resp;
  logic        resp_valid;
  logic        fanfare;
  logic [2:0]  pos_x;
  logic [2:0]  pos_y;
  logic        tour_busy;

  logic [2:0]  mx;                    // Model position, wraps modulo 8.
  logic [2:0]  my;
  logic [7:0]  moves [NUM_MOVES];     // Tour as loaded.
  integer      seed;
  int          errors;                // Errors in the running test.
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  int          checks;

  knight_top #(.NUM_MOVES(NUM_MOVES), .SQUARE_CYCLES(SQUARE_CYCLES)) dut0 (
    .clk, .rst_n, .load_move, .load_valid, .start_tour, .host_cmd, .host_cmd_valid,
    .load_ready, .host_cmd_ready, .resp, .resp_valid, .fanfare, .pos_x, .pos_y, .tour_busy
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;    // 100 ns period.

  ////////////////////////////////////////////////////////////////////////
  // Reporting.
  ////////////////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("Error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("At %0d ns: %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == 0)
      $display("%s: ok", name);
    else begin
      $display("%s: %0d errors", name, errors);
      tests_failed++;
    end
    total_errors += errors;
    errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Board model.
  ////////////////////////////////////////////////////////////////////////
  // One leg of an L; vertical first, then horizontal.
  task automatic apply_leg(input logic [7:0] mv, input bit horiz);
    case (mv)
      8'h01: if (horiz) mx = mx + 3'd1;    // N2, E1.
             else       my = my + 3'd2;
      8'h02: if (horiz) mx = mx - 3'd1;    // N2, W1.
             else       my = my + 3'd2;
      8'h04: if (horiz) mx = mx - 3'd2;    // N1, W2.
             else       my = my + 3'd1;
      8'h08: if (horiz) mx = mx - 3'd2;    // S1, W2.
             else       my = my - 3'd1;
      8'h10: if (horiz) mx = mx - 3'd1;    // S2, W1.
             else       my = my - 3'd2;
      8'h20: if (horiz) mx = mx + 3'd1;    // S2, E1.
             else       my = my - 3'd2;
      8'h40: if (horiz) mx = mx + 3'd2;    // S1, E2.
             else       my = my - 3'd1;
      8'h80: if (horiz) mx = mx + 3'd2;    // N1, E2.
             else       my = my + 3'd1;
      default: ;
    endcase
  endtask

  task automatic apply_host(input logic [15:0] c);
    if (c[15:12] == knight_pkg::OP_PLACE) begin
      mx = c[5:3];                        // Place view, x then y.
      my = c[2:0];
    end else if (c[15:12] == knight_pkg::OP_MOVE || c[15:12] == knight_pkg::OP_MOVE_FANFARE)
      case (c[11:4])
        knight_pkg::NORTH: my = my + c[2:0];   // Square count wraps with the board.
        knight_pkg::SOUTH: my = my - c[2:0];
        knight_pkg::EAST:  mx = mx + c[2:0];
        knight_pkg::WEST:  mx = mx - c[2:0];
        default: ;
      endcase
  endtask

  // Cycles from acceptance to the response.
  function automatic int host_delay(input logic [15:0] c);
    if (c[15:12] == knight_pkg::OP_MOVE || c[15:12] == knight_pkg::OP_MOVE_FANFARE)
      return 1 + int'(c[3:0]) * SQUARE_CYCLES;
    return 1;
  endfunction

  task automatic make_host_cmd(output logic [15:0] c);
    logic [31:0] r;
    logic [7:0]  h;
    r = $random(seed);
    case (r[5:4])
      2'd0:    h = knight_pkg::NORTH;
      2'd1:    h = knight_pkg::WEST;
      2'd2:    h = knight_pkg::SOUTH;
      default: h = knight_pkg::EAST;
    endcase
    if (r[1:0] == 2'd0)
      c = {knight_pkg::OP_PLACE, 6'd0, r[10:8], r[14:12]};
    else if (r[1:0] == 2'd1)
      c = {knight_pkg::OP_MOVE_FANFARE, h, r[19:16]};
    else
      c = {knight_pkg::OP_MOVE, h, r[19:16]};
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Stimulus; drives on the falling edge, samples 10 ns later.
  ////////////////////////////////////////////////////////////////////////
  // Host command already presented in this cycle.
  task automatic exec_host(input logic [15:0] c);
    int cnt;
    while (!host_cmd_ready) begin
      @(negedge clk);
      #10;
    end
    @(negedge clk);
    host_cmd_valid = 1'b0;             // Accepted on the last rising edge.
    cnt = 1;
    #10;
    while (!resp_valid) begin
      @(negedge clk);
      cnt++;
      #10;
    end
    apply_host(c);
    checks++;
    if (cnt != host_delay(c)) report_mismatch("resp_valid delay", cnt, host_delay(c));
    if (resp !== knight_pkg::RESP_DONE) report_mismatch("resp", int'(resp), 8'hA5);
    if (pos_x !== mx) report_mismatch("pos_x", int'(pos_x), int'(mx));
    if (pos_y !== my) report_mismatch("pos_y", int'(pos_y), int'(my));
    if (fanfare !== (c[15:12] == knight_pkg::OP_MOVE_FANFARE))
      report_mismatch("fanfare", int'(fanfare), int'(c[15:12] == knight_pkg::OP_MOVE_FANFARE));
  endtask

  task automatic load_tour();
    logic [31:0] r;
    for (int i = 0; i < NUM_MOVES; i++) begin
      r = $random(seed);
      moves[i] = 8'd1 << r[2:0];        // Random one-hot move.
      @(negedge clk);
      load_move  = moves[i];
      load_valid = 1'b1;
      #10;
      while (!load_ready) begin
        @(negedge clk);
        #10;
      end
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic run_tour(input bit try_load, input bit host_during);
    logic [31:0] r;
    logic [15:0] hc;
    logic        busy;
    int          legs;
    int          fans;
    load_tour();
    make_host_cmd(hc);
    legs = 0;
    fans = 0;
    busy = 1'b1;
    @(negedge clk);
    start_tour = 1'b1;
    load_valid = try_load;              // Blocked by start_tour in this cycle.
    while (busy) begin
      @(negedge clk);
      busy       = tour_busy;           // Registered, settled since the rising edge.
      start_tour = 1'b0;
      r          = $random(seed);
      load_move  = r[7:0];
      load_valid = try_load && busy;
      if (host_during) begin
        host_cmd       = hc;
        host_cmd_valid = 1'b1;          // Held until the tour lets go.
      end
      #10;
      if (busy && load_ready) report_failure("load_ready is high while a tour runs");
      if (busy && host_cmd_ready) report_failure("host command accepted during a tour");
      if (fanfare && !resp_valid) report_failure("fanfare pulsed without a response");
      if (resp_valid) begin
        if (legs >= N_LEGS)
          report_failure("more responses than tour legs");
        else begin
          apply_leg(moves[legs / 2], legs % 2 == 1);
          checks++;
          if (resp !== ((legs == N_LEGS - 1) ? knight_pkg::RESP_DONE : knight_pkg::RESP_BUSY))
            report_mismatch("resp", int'(resp), int'((legs == N_LEGS - 1) ? 8'hA5 : 8'h5A));
          if (pos_x !== mx) report_mismatch("pos_x", int'(pos_x), int'(mx));
          if (pos_y !== my) report_mismatch("pos_y", int'(pos_y), int'(my));
          if (fanfare !== (legs % 2 == 1)) report_mismatch("fanfare", int'(fanfare), legs % 2);
        end
        if (fanfare) fans++;
        legs++;
      end
    end
    if (legs != N_LEGS) report_mismatch("response count", legs, N_LEGS);
    if (fans != NUM_MOVES) report_mismatch("fanfare count", fans, NUM_MOVES);
    if (host_during) exec_host(hc);    // Runs as soon as the sequencer is idle.
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] hc;
    seed           = 32'h220d2cfb;
    rst_n          = 1'b0;
    load_move      = 8'h00;
    load_valid     = 1'b0;
    start_tour     = 1'b0;
    host_cmd       = 16'h0000;
    host_cmd_valid = 1'b0;
    mx             = 3'd0;
    my             = 3'd0;
    errors         = 0;
    total_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    checks         = 0;
    repeat (4) @(posedge clk);          // Reset held for 4 cycles.
    @(negedge clk);
    rst_n = 1'b1;
    #10;

    checks++;
    if (pos_x !== 3'd0) report_mismatch("pos_x", int'(pos_x), 0);
    if (pos_y !== 3'd0) report_mismatch("pos_y", int'(pos_y), 0);
    if (tour_busy !== 1'b0) report_mismatch("tour_busy", int'(tour_busy), 0);
    if (resp_valid !== 1'b0) report_mismatch("resp_valid", int'(resp_valid), 0);
    if (fanfare !== 1'b0) report_mismatch("fanfare", int'(fanfare), 0);
    if (load_ready !== 1'b1) report_mismatch("load_ready", int'(load_ready), 1);
    if (host_cmd_ready !== 1'b0) report_mismatch("host_cmd_ready", int'(host_cmd_ready), 0);
    close_test("test 1 reset values");

    for (int i = 0; i < N_HOST; i++) begin
      make_host_cmd(hc);
      @(negedge clk);
      host_cmd       = hc;
      host_cmd_valid = 1'b1;
      #10;
      exec_host(hc);
    end
    close_test("test 2 host place and move");

    run_tour(1'b0, 1'b0);
    close_test("test 3 tour replay");
    run_tour(1'b1, 1'b0);
    close_test("test 4 load blocked during tour");
    run_tour(1'b0, 1'b1);
    close_test("test 5 host command held off by tour");

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Bounds the run from the length of three tours and the host commands.
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tour_cmd.sv
// Tour sequencer that splits one-hot moves into legs and muxes the command port.
`timescale 1ns/1ps
`default_nettype none

module tour_cmd #(
  parameter int NUM_MOVES = 24
) (
  input  wire  logic                             clk,
  input  wire  logic                             rst_n,
  input  wire  logic                             start_tour,
  input  wire  logic [knight_pkg::MOVE_W-1:0]    move,
  input  wire  logic [knight_pkg::CMD_W-1:0]     host_cmd,
  input  wire  logic                             host_cmd_valid,
  input  wire  logic                             clr_cmd_rdy,
  input  wire  logic                             send_resp,
  output logic [knight_pkg::MV_INDX_W-1:0]       mv_indx,
  output logic                                   host_cmd_ready,
  output knight_pkg::cmd_word_u                  cmd,
  output logic                                   cmd_rdy,
  output logic [7:0]                             resp,
  output logic                                   tour_busy
);

  localparam int IW = knight_pkg::MV_INDX_W;
  localparam logic [IW-1:0] LAST_IDX = IW'(NUM_MOVES - 1);

  // Sequencer states.
  localparam logic [2:0] IDLE  = 3'd0;
  localparam logic [2:0] VERT  = 3'd1; // Vertical leg offered.
  localparam logic [2:0] HOLDV = 3'd2; // Vertical leg in flight.
  localparam logic [2:0] HORZ  = 3'd3; // Horizontal leg offered.
  localparam logic [2:0] HOLDH = 3'd4; // Horizontal leg in flight.

  logic [2:0]            state;
  logic [2:0]            nxt_state;
  logic                  idle;
  logic                  horz_leg;   // Second leg of the L.
  logic                  last_move;
  knight_pkg::heading_t  vert_head;
  knight_pkg::heading_t  horz_head;
  logic [3:0]            vert_sq;
  logic [3:0]            horz_sq;
  knight_pkg::cmd_word_u tour_word;

  assign idle      = (state == IDLE);
  assign horz_leg  = (state == HORZ) || (state == HOLDH);
  assign last_move = (mv_indx == LAST_IDX);
  assign tour_busy = !idle;

  //////////////////////////////////////////////////////////////////////
  // Move index.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      mv_indx <= '0;
    else if (idle && start_tour)
      mv_indx <= '0;                       // First move of the tour.
    else if (state == HOLDH && send_resp && !last_move)
      mv_indx <= mv_indx + 1'b1;           // On to the next L.
  end

  //////////////////////////////////////////////////////////////////////
  // One-hot move to vertical and horizontal legs.
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    vert_head = knight_pkg::NORTH;
    horz_head = knight_pkg::EAST;
    vert_sq   = 4'd0;
    horz_sq   = 4'd0;                      // No move decodes to no motion.
    unique case (1'b1)
      move[0]: begin vert_head = knight_pkg::NORTH; vert_sq = 4'd2;
                     horz_head = knight_pkg::EAST;  horz_sq = 4'd1; end
      move[1]: begin vert_head = knight_pkg::NORTH; vert_sq = 4'd2;
                     horz_head = knight_pkg::WEST;  horz_sq = 4'd1; end
      move[2]: begin vert_head = knight_pkg::NORTH; vert_sq = 4'd1;
                     horz_head = knight_pkg::WEST;  horz_sq = 4'd2; end
      move[3]: begin vert_head = knight_pkg::SOUTH; vert_sq = 4'd1;
                     horz_head = knight_pkg::WEST;  horz_sq = 4'd2; end
      move[4]: begin vert_head = knight_pkg::SOUTH; vert_sq = 4'd2;
                     horz_head = knight_pkg::WEST;  horz_sq = 4'd1; end
      move[5]: begin vert_head = knight_pkg::SOUTH; vert_sq = 4'd2;
                     horz_head = knight_pkg::EAST;  horz_sq = 4'd1; end
      move[6]: begin vert_head = knight_pkg::SOUTH; vert_sq = 4'd1;
                     horz_head = knight_pkg::EAST;  horz_sq = 4'd2; end
      move[7]: begin vert_head = knight_pkg::NORTH; vert_sq = 4'd1;
                     horz_head = knight_pkg::EAST;  horz_sq = 4'd2; end
      default: ;
    endcase
  end

  // Leg command, built through the move view.
  always_comb begin
    tour_word.mv.opcode  = horz_leg ? knight_pkg::OP_MOVE_FANFARE : knight_pkg::OP_MOVE;
    tour_word.mv.heading = horz_leg ? horz_head : vert_head;
    tour_word.mv.squares = horz_leg ? horz_sq : vert_sq;
  end

  //////////////////////////////////////////////////////////////////////
  // Command port mux and response byte.
  //////////////////////////////////////////////////////////////////////
  assign cmd            = idle ? host_cmd : tour_word;   // Host owns the port when idle.
  assign cmd_rdy        = idle ? host_cmd_valid : (state == VERT) || (state == HORZ);
  assign host_cmd_ready = idle && clr_cmd_rdy;

  always_comb begin
    if (idle)
      resp = knight_pkg::RESP_DONE;        // Host commands.
    else if (state == HOLDH && last_move)
      resp = knight_pkg::RESP_DONE;        // Closing leg of the tour.
    else
      resp = knight_pkg::RESP_BUSY;
  end

  //////////////////////////////////////////////////////////////////////
  // Leg sequencer.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      IDLE:    if (start_tour)  nxt_state = VERT;
      VERT:    if (clr_cmd_rdy) nxt_state = HOLDV;
      HOLDV:   if (send_resp)   nxt_state = HORZ;
      HORZ:    if (clr_cmd_rdy) nxt_state = HOLDH;
      HOLDH:   if (send_resp)   nxt_state = last_move ? IDLE : VERT;
      default: nxt_state = IDLE;
    endcase
  end

  // The store must hand over a legal one-hot move for every leg offered.
  a_move_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    (state == VERT || state == HORZ) |-> $onehot(move));

endmodule

`default_nettype wire
